//--- src/videoPixelPkg.sv
//------------------------------
// video pixel pipeline shared definitions
// display sizes, pixel layouts, csr map
//------------------------------
`default_nettype none

package videoPixelPkg;

	//------------------------------
	// display geometry
	//------------------------------
	localparam int hActive = 16;
	localparam int vActive = 8;
	localparam int hWidth = 4;
	localparam int vWidth = 3;

	// sprite placement, rows fixed, column moves
	localparam int squareSize = 4;
	localparam int squareTop = 2;

	// fade level range 0..fadeMax
	localparam int levelWidth = 5;
	localparam logic [levelWidth-1:0] fadeMax = 5'd16;

	// output buffer entries
	localparam int fifoDepth = 16;

	//------------------------------
	// apb register map
	//------------------------------
	localparam logic [7:0] ctrlAddr = 8'h00;
	localparam logic [7:0] sceneColorAddr = 8'h04;
	localparam logic [7:0] frameTimingAddr = 8'h08;
	localparam logic [7:0] squareColorAddr = 8'h0C;
	localparam logic [7:0] bgColorAddr = 8'h10;
	localparam logic [7:0] statusAddr = 8'h14;

	// argb4444 colour
	typedef struct packed {
		logic [3:0] alpha;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} argbT;

	// csr keeps raw, datapath reads channels
	typedef union packed {
		argbT argb;
		logic [15:0] raw;
	} pixelU;

	typedef struct packed {
		logic [hWidth-1:0] hpos;
		logic [vWidth-1:0] vpos;
		logic firstPixel;
	} drawPosT;

	// register contents toward the datapath
	typedef struct packed {
		pixelU sceneColor;
		pixelU squareColor;
		pixelU bgColor;
		logic [6:0] frameTiming;
		logic fadeAddEn;
		logic fadeSubEn;
		logic fadeRst;
	} csrCfgT;

	// display side word, alpha already removed
	typedef struct packed {
		logic sof;
		logic [11:0] rgb;
	} fifoWordT;

endpackage

`default_nettype wire

//--- src/pixelDrawPosition.sv
//------------------------------
// draw position counter
// walks the active area, flags frame end
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixelDrawPosition (
	input logic iCLK,
	input logic iRST,
	input logic cke,
	output videoPixelPkg::drawPosT pos,
	output logic frameEnd
);

	logic lastCol;
	logic lastRow;
	logic [videoPixelPkg::hWidth-1:0] hNext;
	logic [videoPixelPkg::vWidth-1:0] vNext;

	// end of line / end of frame detect
	assign lastCol = (int'(pos.hpos) == videoPixelPkg::hActive - 1);
	assign lastRow = (int'(pos.vpos) == videoPixelPkg::vActive - 1);

	// one cycle wide, only on an enabled step
	assign frameEnd = cke & lastCol & lastRow;

	//------------------------------
	// next position
	//------------------------------
	always_comb
	begin
		hNext = pos.hpos + 1'b1;
		vNext = pos.vpos;
		if (lastCol)
		begin
			hNext = '0;
			// wrap rows at the bottom
			if (lastRow)
				vNext = '0;
			else
				vNext = pos.vpos + 1'b1;
		end
	end

	// first output after reset is 0,0
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pos.hpos <= '0;
			pos.vpos <= '0;
			pos.firstPixel <= 1'b1;
		end
		else if (cke)
		begin
			pos.hpos <= hNext;
			pos.vpos <= vNext;
			// next one is 0,0 exactly when wrapping the frame
			pos.firstPixel <= lastCol & lastRow;
		end
	end

endmodule

`default_nettype wire

//--- src/dotSquareGen.sv
//------------------------------
// square sprite painter
// square over background, moves a column per frame
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module dotSquareGen (
	input logic iCLK,
	input logic iRST,
	input logic cke,
	input videoPixelPkg::drawPosT pos,
	input logic frameEnd,
	input videoPixelPkg::csrCfgT cfg,
	output videoPixelPkg::pixelU pixel,
	output logic sof,
	output logic valid
);

	// left column of the square
	logic [videoPixelPkg::hWidth-1:0] left;
	int colOffset;
	logic inCol;
	logic inRow;

	//------------------------------
	// hit test
	//------------------------------
	always_comb
	begin
		// distance from left edge, wrapped around the line
		colOffset = int'(pos.hpos) - int'(left);
		if (colOffset < 0)
			colOffset = colOffset + videoPixelPkg::hActive;
		inCol = (colOffset < videoPixelPkg::squareSize);
		// fixed row band
		inRow = (int'(pos.vpos) >= videoPixelPkg::squareTop) &&
			(int'(pos.vpos) < videoPixelPkg::squareTop + videoPixelPkg::squareSize);
	end

	// step right once per frame
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			left <= '0;
		else if (frameEnd)
		begin
			if (int'(left) == videoPixelPkg::hActive - 1)
				left <= '0;
			else
				left <= left + 1'b1;
		end
	end

	// stage control
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			sof <= 1'b0;
			valid <= 1'b0;
		end
		else if (cke)
		begin
			sof <= pos.firstPixel;
			// stays high once the pipe has filled
			valid <= 1'b1;
		end
	end

	// colour select
	always_ff @(posedge iCLK)
	begin
		if (cke)
			pixel <= (inCol && inRow) ? cfg.squareColor : cfg.bgColor;
	end

endmodule

`default_nettype wire

//--- src/sceneFade.sv
//------------------------------
// scene change fade
// steps level per frame, blends toward scene colour
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module sceneFade (
	input logic iCLK,
	input logic iRST,
	input logic cke,
	input videoPixelPkg::pixelU pixelIn,
	input logic sofIn,
	input logic validIn,
	input videoPixelPkg::csrCfgT cfg,
	output logic [videoPixelPkg::levelWidth-1:0] level,
	output videoPixelPkg::fifoWordT out,
	output logic outValid
);

	logic [6:0] frameCnt;
	logic [6:0] frameCntNext;
	logic [6:0] timing;
	logic frameAccept;
	logic stepDue;
	logic [videoPixelPkg::levelWidth-1:0] levelNext;
	logic [videoPixelPkg::levelWidth-1:0] levelUse;

	// (p * (max - lv) + s * lv) >> 4
	function automatic logic [3:0] blendCh(
		input logic [3:0] p,
		input logic [3:0] s,
		input logic [videoPixelPkg::levelWidth-1:0] lv
	);
		logic [videoPixelPkg::levelWidth-1:0] inv;
		logic [8:0] acc;
		inv = videoPixelPkg::fadeMax - lv;
		acc = {5'd0, p} * {4'd0, inv} + {5'd0, s} * {4'd0, lv};
		return acc[7:4];
	endfunction

	//------------------------------
	// frame pacing
	//------------------------------
	// zero timing behaves as every frame
	assign timing = (cfg.frameTiming == 7'd0) ? 7'd1 : cfg.frameTiming;
	assign frameAccept = cke & validIn & sofIn;
	assign frameCntNext = frameCnt + 1'b1;
	// >= so a lowered timing does not stall the count
	assign stepDue = (frameCntNext >= timing);

	always_comb
	begin
		levelNext = level;
		if (stepDue)
		begin
			// fade in wins over fade out
			if (cfg.fadeAddEn && (level < videoPixelPkg::fadeMax))
				levelNext = level + 1'b1;
			else if (cfg.fadeSubEn && (level != '0))
				levelNext = level - 1'b1;
		end
	end

	// new level already covers the sof pixel
	assign levelUse = (validIn && sofIn) ? levelNext : level;

	always_ff @(posedge iCLK)
	begin
		if (iRST || cfg.fadeRst)
		begin
			level <= '0;
			frameCnt <= '0;
		end
		else if (frameAccept)
		begin
			frameCnt <= stepDue ? 7'd0 : frameCntNext;
			level <= levelNext;
		end
	end

	//------------------------------
	// blend stage
	//------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			outValid <= 1'b0;
		else if (cke)
			outValid <= validIn;
	end

	// alpha dropped here
	always_ff @(posedge iCLK)
	begin
		if (cke)
		begin
			out.sof <= sofIn;
			out.rgb <= {blendCh(pixelIn.argb.red, cfg.sceneColor.argb.red, levelUse),
				blendCh(pixelIn.argb.green, cfg.sceneColor.argb.green, levelUse),
				blendCh(pixelIn.argb.blue, cfg.sceneColor.argb.blue, levelUse)};
		end
	end

endmodule

`default_nettype wire

//--- src/pixelFifo.sv
//------------------------------
// output pixel fifo
// circular buffer, almost full for back-pressure
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixelFifo (
	input logic iCLK,
	input logic iRST,
	input videoPixelPkg::fifoWordT wd,
	input logic we,
	output logic almostFull,
	input logic re,
	output videoPixelPkg::fifoWordT rd,
	output logic rvd,
	output logic emp
);

	videoPixelPkg::fifoWordT mem [videoPixelPkg::fifoDepth];
	logic [$clog2(videoPixelPkg::fifoDepth)-1:0] wp;
	logic [$clog2(videoPixelPkg::fifoDepth)-1:0] rp;
	logic [$clog2(videoPixelPkg::fifoDepth):0] count;
	logic full;
	logic doWrite;
	logic doRead;

	assign full = (int'(count) == videoPixelPkg::fifoDepth);
	assign emp = (count == '0);
	// leaves room for the two stages still in flight
	assign almostFull = (int'(count) >= videoPixelPkg::fifoDepth - 3);

	// requests on empty or full are dropped
	assign doWrite = we & ~full;
	assign doRead = re & ~emp;

	//------------------------------
	// pointers and occupancy
	//------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wp <= '0;
			rp <= '0;
			count <= '0;
			rvd <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wp <= wp + 1'b1;
			if (doRead)
				rp <= rp + 1'b1;
			// both at once leaves count alone
			if (doWrite && !doRead)
				count <= count + 1'b1;
			else if (doRead && !doWrite)
				count <= count - 1'b1;
			rvd <= doRead;
		end
	end

	// storage and registered read port
	always_ff @(posedge iCLK)
	begin
		if (doWrite)
			mem[wp] <= wd;
		if (doRead)
			rd <= mem[rp];
	end

endmodule

`default_nettype wire

//--- src/videoCsrApb.sv
//------------------------------
// apb control and status registers
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module videoCsrApb (
	input logic iCLK,
	input logic iRST,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [videoPixelPkg::levelWidth-1:0] level,
	output videoPixelPkg::csrCfgT cfg
);

	logic access;
	logic addrHit;
	logic statusSel;
	logic writeEn;
	logic [31:0] statusWord;

	// access phase, no wait states
	assign access = psel & penable;
	assign pready = 1'b1;
	assign statusSel = (paddr == videoPixelPkg::statusAddr);

	// level in 12:8, min at bit 1, max at bit 0
	assign statusWord = {19'd0, level, 6'd0, (level == '0),
		(level == videoPixelPkg::fadeMax)};

	//------------------------------
	// read mux and address decode
	//------------------------------
	always_comb
	begin
		prdata = '0;
		addrHit = 1'b1;
		case (paddr)
			videoPixelPkg::ctrlAddr:
				prdata = {30'd0, cfg.fadeSubEn, cfg.fadeAddEn};
			videoPixelPkg::sceneColorAddr:
				prdata = {16'd0, cfg.sceneColor.raw};
			videoPixelPkg::frameTimingAddr:
				prdata = {25'd0, cfg.frameTiming};
			videoPixelPkg::squareColorAddr:
				prdata = {16'd0, cfg.squareColor.raw};
			videoPixelPkg::bgColorAddr:
				prdata = {16'd0, cfg.bgColor.raw};
			videoPixelPkg::statusAddr:
				prdata = statusWord;
			default:
				addrHit = 1'b0;
		endcase
	end

	// unmapped, or status written
	assign pslverr = access & (~addrHit | (pwrite & statusSel));
	assign writeEn = access & pwrite & addrHit & ~statusSel;

	//------------------------------
	// register file
	//------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			cfg <= '0;
		else
		begin
			// reset strobe lasts one cycle
			cfg.fadeRst <= 1'b0;
			if (writeEn)
			begin
				case (paddr)
					videoPixelPkg::ctrlAddr:
					begin
						cfg.fadeAddEn <= pwdata[0];
						cfg.fadeSubEn <= pwdata[1];
						cfg.fadeRst <= pwdata[2];
					end
					videoPixelPkg::sceneColorAddr:
						cfg.sceneColor.raw <= pwdata[15:0];
					videoPixelPkg::frameTimingAddr:
						cfg.frameTiming <= pwdata[6:0];
					videoPixelPkg::squareColorAddr:
						cfg.squareColor.raw <= pwdata[15:0];
					videoPixelPkg::bgColorAddr:
						cfg.bgColor.raw <= pwdata[15:0];
					default:
						cfg.fadeRst <= 1'b0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- src/videoPixelGen.sv
//------------------------------
// video pixel generator top
// csr, position, painter, fade, output fifo
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module videoPixelGen (
	input logic iCLK,
	input logic iRST,
	// apb slave
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// pixel read port
	input logic re,
	output videoPixelPkg::fifoWordT rd,
	output logic rvd,
	output logic emp
);

	videoPixelPkg::csrCfgT cfg;
	logic [videoPixelPkg::levelWidth-1:0] level;
	videoPixelPkg::drawPosT pos;
	logic frameEnd;
	videoPixelPkg::pixelU squarePixel;
	logic squareSof;
	logic squareValid;
	videoPixelPkg::fifoWordT fadeWord;
	logic fadeValid;
	logic almostFull;
	logic cke;
	logic fifoWe;

	// whole pipe holds together under back-pressure
	assign cke = ~almostFull;
	assign fifoWe = fadeValid & cke;

	//------------------------------
	// control
	//------------------------------
	videoCsrApb csrInst (
		.iCLK(iCLK), .iRST(iRST),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.level(level), .cfg(cfg)
	);

	//------------------------------
	// pixel pipeline
	//------------------------------
	pixelDrawPosition posInst (
		.iCLK(iCLK), .iRST(iRST), .cke(cke),
		.pos(pos), .frameEnd(frameEnd)
	);

	dotSquareGen squareInst (
		.iCLK(iCLK), .iRST(iRST), .cke(cke),
		.pos(pos), .frameEnd(frameEnd), .cfg(cfg),
		.pixel(squarePixel), .sof(squareSof), .valid(squareValid)
	);

	sceneFade fadeInst (
		.iCLK(iCLK), .iRST(iRST), .cke(cke),
		.pixelIn(squarePixel), .sofIn(squareSof), .validIn(squareValid),
		.cfg(cfg), .level(level),
		.out(fadeWord), .outValid(fadeValid)
	);

	// display side hand-off
	pixelFifo fifoInst (
		.iCLK(iCLK), .iRST(iRST),
		.wd(fadeWord), .we(fifoWe), .almostFull(almostFull),
		.re(re), .rd(rd), .rvd(rvd), .emp(emp)
	);

endmodule

`default_nettype wire

//--- testbench/videoPixelGen_tb.sv
//------------------------------
// video pixel generator testbench
// apb setup per table row, fifo drain, pixel model
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module videoPixelGen_tb;

	// one stimulus row
	typedef struct packed {
		logic [15:0] squareColor;
		logic [15:0] bgColor;
		logic [15:0] sceneColor;
		logic [6:0] frameTiming;
		logic addEn;
		logic subEn;
		logic rstEn;
		logic [7:0] frames;
		logic [31:0] status;
	} stimRowT;

	logic iCLK;
	logic iRST;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic re;
	videoPixelPkg::fifoWordT rd;
	logic rvd;
	logic emp;

	stimRowT stim [5];
	int errCount;
	int frameIdx;
	// reference state
	int modelLevel;
	int modelCnt;
	logic [15:0] curSq;
	logic [15:0] curBg;
	logic [15:0] curScene;
	logic [6:0] curTiming;
	logic curAdd;
	logic curSub;

	videoPixelGen videoPixelGen_inst (
		.iCLK(iCLK), .iRST(iRST),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.re(re), .rd(rd), .rvd(rvd), .emp(emp)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #50 iCLK = ~iCLK;
	end

	//------------------------------
	// table and reference model
	//------------------------------
	// square, bg, scene, timing, add, sub, rst, frames, end status
	task automatic loadTable();
		stim[0] = {16'hFF00, 16'hF00F, 16'hF0F0, 7'd1, 1'b0, 1'b0, 1'b1, 8'd17, 32'h0000_0002};
		stim[1] = {16'hF840, 16'hF123, 16'hFFFF, 7'd2, 1'b1, 1'b0, 1'b1, 8'd34, 32'h0000_1001};
		// no fade reset, falls from 16
		stim[2] = {16'hF0F0, 16'hF800, 16'hF888, 7'd1, 1'b0, 1'b1, 1'b0, 8'd18, 32'h0000_0002};
		stim[3] = {16'hF4C2, 16'hF06A, 16'hFF80, 7'd1, 1'b1, 1'b0, 1'b1, 8'd6, 32'h0000_0700};
		// zero timing acts as one, steps every frame
		stim[4] = {16'hF5A5, 16'hF0F0, 16'hF333, 7'd0, 1'b1, 1'b0, 1'b1, 8'd3, 32'h0000_0400};
	endtask

	// level and frame counter update at each sof
	task automatic stepModelFrame();
		int t;
		t = (curTiming == 7'd0) ? 1 : int'(curTiming);
		modelCnt = modelCnt + 1;
		if (modelCnt >= t)
		begin
			modelCnt = 0;
			if (curAdd && (modelLevel < 16))
				modelLevel = modelLevel + 1;
			else if (curSub && (modelLevel > 0))
				modelLevel = modelLevel - 1;
		end
	endtask

	function automatic logic [3:0] blendChannel(logic [3:0] p, logic [3:0] s, int lv);
		int res;
		res = (int'(p) * (16 - lv) + int'(s) * lv) / 16;
		return res[3:0];
	endfunction

	function automatic logic [31:0] statusFor(int lv);
		logic [31:0] word;
		word = 32'(lv) << 8;
		word[1] = (lv == 0);
		word[0] = (lv == 16);
		return word;
	endfunction

	// square rule then fade rule, alpha dropped
	function automatic logic [12:0] expectedWord(int frame, int idx, int lv);
		int h;
		int v;
		int off;
		logic [15:0] src;
		logic [11:0] rgb;
		h = idx % videoPixelPkg::hActive;
		v = idx / videoPixelPkg::hActive;
		off = (h - (frame % videoPixelPkg::hActive) + videoPixelPkg::hActive)
			% videoPixelPkg::hActive;
		if ((off < videoPixelPkg::squareSize) && (v >= videoPixelPkg::squareTop)
			&& (v < videoPixelPkg::squareTop + videoPixelPkg::squareSize))
			src = curSq;
		else
			src = curBg;
		rgb[11:8] = blendChannel(src[11:8], curScene[11:8], lv);
		rgb[7:4] = blendChannel(src[7:4], curScene[7:4], lv);
		rgb[3:0] = blendChannel(src[3:0], curScene[3:0], lv);
		return {idx == 0, rgb};
	endfunction

	//------------------------------
	// bus and port helpers
	//------------------------------
	task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			errCount = errCount + 1;
		end
	endtask

	// setup phase, then access phase sampled mid-cycle
	task automatic writeReg(logic [7:0] a, logic [31:0] d, output logic err);
		@(posedge iCLK);
		#1;
		paddr = a;
		pwdata = d;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge iCLK);
		#1;
		penable = 1'b1;
		#1;
		err = pslverr;
		if (!pready)
		begin
			$display("pready low in apb write access phase at %0t", $time);
			errCount = errCount + 1;
		end
		@(posedge iCLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic readReg(logic [7:0] a, output logic [31:0] d, output logic err);
		@(posedge iCLK);
		#1;
		paddr = a;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge iCLK);
		#1;
		penable = 1'b1;
		#1;
		d = prdata;
		err = pslverr;
		if (!pready)
		begin
			$display("pready low in apb read access phase at %0t", $time);
			errCount = errCount + 1;
		end
		@(posedge iCLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// one word per call, random idle cycles in between
	task automatic readWord(output videoPixelPkg::fifoWordT w);
		logic got;
		got = 1'b0;
		while (!got)
		begin
			@(posedge iCLK);
			#1;
			if (!emp && (($urandom % 4) != 0))
			begin
				re = 1'b1;
				@(posedge iCLK);
				#1;
				re = 1'b0;
				if (!rvd)
				begin
					$display("rvd stayed low after a read at %0t", $time);
					errCount = errCount + 1;
				end
				w = rd;
				got = 1'b1;
			end
		end
	endtask

	// writes one row, reads everything back
	task automatic applyRow(int r);
		logic err;
		logic [31:0] data;
		writeReg(videoPixelPkg::squareColorAddr, {16'd0, stim[r].squareColor}, err);
		compareValue("pslverr", {31'd0, err}, 32'd0);
		writeReg(videoPixelPkg::bgColorAddr, {16'd0, stim[r].bgColor}, err);
		compareValue("pslverr", {31'd0, err}, 32'd0);
		writeReg(videoPixelPkg::sceneColorAddr, {16'd0, stim[r].sceneColor}, err);
		compareValue("pslverr", {31'd0, err}, 32'd0);
		writeReg(videoPixelPkg::frameTimingAddr, {25'd0, stim[r].frameTiming}, err);
		compareValue("pslverr", {31'd0, err}, 32'd0);
		writeReg(videoPixelPkg::ctrlAddr,
			{29'd0, stim[r].rstEn, stim[r].subEn, stim[r].addEn}, err);
		compareValue("pslverr", {31'd0, err}, 32'd0);
		curSq = stim[r].squareColor;
		curBg = stim[r].bgColor;
		curScene = stim[r].sceneColor;
		curTiming = stim[r].frameTiming;
		curAdd = stim[r].addEn;
		curSub = stim[r].subEn;
		if (stim[r].rstEn)
		begin
			modelLevel = 0;
			modelCnt = 0;
		end
		// read back
		readReg(videoPixelPkg::squareColorAddr, data, err);
		compareValue("squareColor", data, {16'd0, curSq});
		readReg(videoPixelPkg::bgColorAddr, data, err);
		compareValue("bgColor", data, {16'd0, curBg});
		readReg(videoPixelPkg::sceneColorAddr, data, err);
		compareValue("sceneColor", data, {16'd0, curScene});
		readReg(videoPixelPkg::frameTimingAddr, data, err);
		compareValue("frameTiming", data, {25'd0, curTiming});
		readReg(videoPixelPkg::ctrlAddr, data, err);
		compareValue("ctrl", data, {30'd0, curSub, curAdd});
		// fade reset shows at once
		readReg(videoPixelPkg::statusAddr, data, err);
		compareValue("status", data, statusFor(modelLevel));
		compareValue("pslverr", {31'd0, err}, 32'd0);
	endtask

	//------------------------------
	// main sequence
	//------------------------------
	initial
	begin
		videoPixelPkg::fifoWordT w;
		int count;
		int r;
		int f;
		int i;
		logic err;
		logic [31:0] data;
		iRST = 1'b1;
		re = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'd0;
		pwdata = 32'd0;
		errCount = 0;
		frameIdx = 0;
		modelLevel = 0;
		modelCnt = 0;
		curSq = 16'd0;
		curBg = 16'd0;
		curScene = 16'd0;
		curTiming = 7'd0;
		curAdd = 1'b0;
		curSub = 1'b0;
		loadTable();
		void'($urandom(46059));
		repeat (4) @(posedge iCLK);
		#1;
		iRST = 1'b0;
		compareValue("emp", {31'd0, emp}, 32'd1);
		compareValue("rvd", {31'd0, rvd}, 32'd0);
		// frame 0 painted with all registers at zero
		readWord(w);
		compareValue("rd first word", {19'd0, w}, {19'd0, 13'h1000});
		stepModelFrame();
		for (r = 0; r < $size(stim); r++)
		begin
			// reading stopped right after a sof, next sof not yet painted
			applyRow(r);
			count = 1;
			readWord(w);
			while (!w.sof)
			begin
				count = count + 1;
				readWord(w);
			end
			compareValue("sof spacing", count,
				videoPixelPkg::hActive * videoPixelPkg::vActive);
			frameIdx = frameIdx + 1;
			stepModelFrame();
			for (f = 0; f < int'(stim[r].frames); f++)
			begin
				for (i = 0; i < videoPixelPkg::hActive * videoPixelPkg::vActive; i++)
				begin
					if (i != 0)
						readWord(w);
					compareValue($sformatf("rd frame %0d pixel %0d", frameIdx, i),
						{19'd0, w}, {19'd0, expectedWord(frameIdx, i, modelLevel)});
				end
				readWord(w);
				if (!w.sof)
				begin
					$display("no sof after 128 words of frame %0d", frameIdx);
					errCount = errCount + 1;
				end
				frameIdx = frameIdx + 1;
				stepModelFrame();
			end
			readReg(videoPixelPkg::statusAddr, data, err);
			compareValue("status", data, stim[r].status);
		end
		// error responses
		writeReg(8'h3C, 32'h1234, err);
		compareValue("pslverr unmapped write", {31'd0, err}, 32'd1);
		readReg(8'h3C, data, err);
		compareValue("pslverr unmapped read", {31'd0, err}, 32'd1);
		writeReg(videoPixelPkg::statusAddr, 32'hFFFF, err);
		compareValue("pslverr status write", {31'd0, err}, 32'd1);
		$display("errors: %0d", errCount);
		if (errCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// run limit from table length
	initial
	begin
		int total;
		int k;
		int limit;
		#1;
		total = 1;
		for (k = 0; k < $size(stim); k++)
			total = total + int'(stim[k].frames) + 1;
		limit = total * 128 * 4 + 2000;
		repeat (limit) @(posedge iCLK);
		$display("timeout after %0d clock periods, pixel stream stalled", limit);
		$display("errors: %0d", errCount);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- videoPixelGen.f
src/videoPixelPkg.sv
src/pixelDrawPosition.sv
src/dotSquareGen.sv
src/sceneFade.sv
src/pixelFifo.sv
src/videoCsrApb.sv
src/videoPixelGen.sv
testbench/videoPixelGen_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP = videoPixelGen_tb
RTL_TOP = videoPixelGen
FILELIST = videoPixelGen.f
BUILD_DIR = obj_dir
PASS_TEXT = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
